// ==== logic/ncpu_cfg_pkg.sv ====
/*
 * NCPU configuration package
 * Core-wide sizes for the system-register side: data width,
 * number of interrupt lines, the line shared by the timestamp
 * counter, and the depth of the interrupt synchronizer
 */
package ncpu_cfg_pkg;

   // Register and APB data width
   localparam int NCPU_DW = 32;

   // Level-sensitive interrupt lines into the IRQC
   localparam int NCPU_NIRQ = 32;

   // TSC interrupt is ORed onto this line
   localparam int NCPU_IRQ_N_TSC = 0;

   // Flops in front of IRR, two for metastability
   localparam int NCPU_SYNC_STAGES = 2;

   // Derived values used by several blocks
   localparam int NCPU_DB = NCPU_DW / 8;   // Bytes per register
   localparam int NCPU_SYNC_LAST = NCPU_SYNC_STAGES - 1;   // Output stage index

endpackage

// ==== logic/ncpu_msr_pkg.sv ====
/*
 * Machine-status register map
 * Byte addresses of PSR, IMR, IRR, TSR and TCR on the APB port,
 * TCR and PSR field positions, and the IMR value after reset
 */
package ncpu_msr_pkg;

   // APB address width
   localparam int MSR_AW = 8;

   // Register byte addresses
   localparam logic [MSR_AW-1:0] MSR_PSR_ADDR = 8'h00;   // Processor status
   localparam logic [MSR_AW-1:0] MSR_IMR_ADDR = 8'h04;   // Interrupt mask
   localparam logic [MSR_AW-1:0] MSR_IRR_ADDR = 8'h08;   // Pending, read-only
   localparam logic [MSR_AW-1:0] MSR_TSR_ADDR = 8'h0C;   // Timestamp count
   localparam logic [MSR_AW-1:0] MSR_TCR_ADDR = 8'h10;   // Timestamp control

   // TCR layout
   //   [27:0] CNT  compare value against TSR low bits
   //   [28]   EN   count enable
   //   [29]   I    interrupt enable
   //   [30]   P    pending, cleared by writing 0
   //   [31]   reserved
   localparam int TCR_CNT_W = 28;   // Compare field width
   localparam int TCR_EN_BIT = 28;  // Count enable
   localparam int TCR_I_BIT = 29;   // Interrupt enable
   localparam int TCR_P_BIT = 30;   // Pending

   // PSR layout, only IRE is implemented
   localparam int PSR_IRE_BIT = 0;  // Global interrupt enable

   // All lines masked out of reset
   localparam logic [ncpu_cfg_pkg::NCPU_DW-1:0] IMR_RESET = '1;

endpackage

// ==== logic/ncpu_msr_apb.sv ====
/*
 * APB slave for the machine-status registers
 * Decodes PSR, IMR, IRR, TSR and TCR, raises one write strobe
 * per valid write, keeps the PSR.IRE bit and returns read data
 * in the access cycle. Zero wait states; pslverr flags unmapped
 * addresses and writes to IRR
 */
module ncpu_msr_apb (
   input  logic                             clk,
   input  logic                             rst,
   // APB
   input  logic                             psel,
   input  logic                             penable,
   input  logic                             pwrite,
   input  logic [ncpu_msr_pkg::MSR_AW-1:0]  paddr,
   input  logic [ncpu_cfg_pkg::NCPU_DW-1:0] pwdata,
   output logic [ncpu_cfg_pkg::NCPU_DW-1:0] prdata,
   output logic                             pready,
   output logic                             pslverr,
   // Register values for readback
   input  logic [ncpu_cfg_pkg::NCPU_DW-1:0] tsr,
   input  logic [ncpu_cfg_pkg::NCPU_DW-1:0] tcr,
   input  logic [ncpu_cfg_pkg::NCPU_DW-1:0] imr,
   input  logic [ncpu_cfg_pkg::NCPU_DW-1:0] irr,
   // Write side
   output logic [ncpu_cfg_pkg::NCPU_DW-1:0] wdata,
   output logic                             tsr_we,
   output logic                             tcr_we,
   output logic                             imr_we,
   output logic                             psr_ire
);
   import ncpu_cfg_pkg::*;
   import ncpu_msr_pkg::*;

   logic               access;    // Second APB phase
   logic               sel_psr;
   logic               sel_imr;
   logic               sel_irr;
   logic               sel_tsr;
   logic               sel_tcr;
   logic               mapped;    // Any register hit
   logic               bad_wr;    // Write to read-only IRR
   logic               wr_ok;     // Write that takes effect
   logic               psr_we;
   logic [NCPU_DW-1:0] psr_rd;    // PSR as seen by software

   assign access = psel & penable;   // Setup has penable low

   // Full address compare, misaligned offsets are unmapped
   assign sel_psr = (paddr == MSR_PSR_ADDR);
   assign sel_imr = (paddr == MSR_IMR_ADDR);
   assign sel_irr = (paddr == MSR_IRR_ADDR);
   assign sel_tsr = (paddr == MSR_TSR_ADDR);
   assign sel_tcr = (paddr == MSR_TCR_ADDR);
   assign mapped  = sel_psr | sel_imr | sel_irr | sel_tsr | sel_tcr;
   assign bad_wr  = pwrite & sel_irr;

   // No wait states
   assign pready  = access;
   assign pslverr = access & (~mapped | bad_wr);   // Same cycle as pready

   // Strobes fire in the access cycle, so the write lands at its end
   assign wr_ok  = access & pwrite & mapped & ~bad_wr;
   assign psr_we = wr_ok & sel_psr;
   assign imr_we = wr_ok & sel_imr;
   assign tsr_we = wr_ok & sel_tsr;
   assign tcr_we = wr_ok & sel_tcr;
   assign wdata  = pwdata;   // Shared write bus to TSC and IRQC

   // PSR, only IRE is kept
   always_ff @(posedge clk) begin
      if (rst) begin
         psr_ire <= 1'b0;   // Interrupts off after reset
      end else if (psr_we) begin
         psr_ire <= pwdata[PSR_IRE_BIT];
      end
   end

   assign psr_rd = NCPU_DW'(psr_ire) << PSR_IRE_BIT;   // Other PSR bits read 0

   // Read mux, valid whenever paddr is stable
   always_comb begin
      case (paddr)
         MSR_PSR_ADDR: prdata = psr_rd;
         MSR_IMR_ADDR: prdata = imr;
         MSR_IRR_ADDR: prdata = irr;
         MSR_TSR_ADDR: prdata = tsr;
         MSR_TCR_ADDR: prdata = tcr;
         default:      prdata = '0;   // Unmapped reads zero
      endcase
   end

endmodule

// ==== logic/ncpu_tsc.sv ====
/*
 * Timestamp counter
 * TSR counts up each clock while TCR.EN is set. When its low
 * bits meet TCR.CNT with EN and I set, TCR.P is raised on the
 * next clock and drives the timer interrupt until software
 * writes TCR with P low
 */
module ncpu_tsc (
   input  logic                             clk,
   input  logic                             rst,
   input  logic [ncpu_cfg_pkg::NCPU_DW-1:0] wdata,
   input  logic                             tsr_we,
   input  logic                             tcr_we,
   output logic [ncpu_cfg_pkg::NCPU_DW-1:0] tsr,
   output logic [ncpu_cfg_pkg::NCPU_DW-1:0] tcr,
   output logic                             tsc_irq
);
   import ncpu_cfg_pkg::*;
   import ncpu_msr_pkg::*;

   logic [NCPU_DW-1:0] tsr_q;     // Free-running count
   logic [NCPU_DW-1:0] tcr_q;     // CNT, EN, I, P
   logic [NCPU_DW-1:0] tcr_nxt;
   logic               cnt_en;
   logic               irq_en;
   logic               match;     // Compare hit this cycle

   assign cnt_en = tcr_q[TCR_EN_BIT];
   assign irq_en = tcr_q[TCR_I_BIT];

   // Only the CNT-wide low field of TSR takes part
   assign match = cnt_en & irq_en &
                  (tsr_q[TCR_CNT_W-1:0] == tcr_q[TCR_CNT_W-1:0]);

   // Counter, software write wins over the increment
   always_ff @(posedge clk) begin
      if (rst) begin
         tsr_q <= '0;
      end else if (tsr_we) begin
         tsr_q <= wdata;
      end else if (cnt_en) begin
         tsr_q <= tsr_q + 1'b1;   // Wraps at 2^32
      end
   end

   // Next TCR
   // A write may clear P but never set it, so P only
   // comes from a compare hit with I already on
   always_comb begin
      tcr_nxt = tcr_q;
      if (tcr_we) begin
         tcr_nxt = wdata;
         tcr_nxt[TCR_P_BIT] = tcr_q[TCR_P_BIT] & wdata[TCR_P_BIT];   // Write 0 clears
      end else if (match) begin
         tcr_nxt[TCR_P_BIT] = 1'b1;   // Sticky until cleared
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         tcr_q <= '0;   // Stopped, no interrupt
      end else begin
         tcr_q <= tcr_nxt;
      end
   end

   assign tsr     = tsr_q;
   assign tcr     = tcr_q;
   assign tsc_irq = tcr_q[TCR_P_BIT];   // Level while pending

endmodule

// ==== logic/ncpu_irqc.sv ====
/*
 * Interrupt controller
 * Synchronizes the level-sensitive lines, masks them with IMR
 * and registers the result as IRR. intr is raised while IRR has
 * a bit set and PSR.IRE is on
 */
module ncpu_irqc (
   input  logic                               clk,
   input  logic                               rst,
   input  logic [ncpu_cfg_pkg::NCPU_NIRQ-1:0] irqs,
   input  logic                               psr_ire,
   input  logic [ncpu_cfg_pkg::NCPU_DW-1:0]   wdata,
   input  logic                               imr_we,
   output logic [ncpu_cfg_pkg::NCPU_DW-1:0]   imr,
   output logic [ncpu_cfg_pkg::NCPU_DW-1:0]   irr,
   output logic                               intr
);
   import ncpu_cfg_pkg::*;
   import ncpu_msr_pkg::*;

   logic [NCPU_NIRQ-1:0] sync_q [NCPU_SYNC_STAGES];   // Stage 0 sees raw lines
   logic [NCPU_DW-1:0]   imr_q;   // 1 masks a line
   logic [NCPU_DW-1:0]   irr_q;

   // Synchronizer chain
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NCPU_SYNC_STAGES; i++) begin
            sync_q[i] <= '0;
         end
      end else begin
         sync_q[0] <= irqs;   // Asynchronous sources
         for (int i = 1; i < NCPU_SYNC_STAGES; i++) begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   // Mask register
   always_ff @(posedge clk) begin
      if (rst) begin
         imr_q <= IMR_RESET;   // Everything masked
      end else if (imr_we) begin
         imr_q <= wdata;
      end
   end

   // Pending lines, one clock behind the synchronizer
   always_ff @(posedge clk) begin
      if (rst) begin
         irr_q <= '0;
      end else begin
         irr_q <= NCPU_DW'(sync_q[NCPU_SYNC_LAST]) & ~imr_q;
      end
   end

   assign imr  = imr_q;
   assign irr  = irr_q;
   assign intr = psr_ire & (|irr_q);   // Straight from registers

endmodule

// ==== logic/ncpu_periph.sv ====
/*
 * System-register top level
 * APB slave in front of the timestamp counter and interrupt
 * controller. The timer interrupt shares its IRQ line with the
 * external line of the same number
 */
module ncpu_periph (
   input  logic                               clk,
   input  logic                               rst,
   // APB
   input  logic                               psel,
   input  logic                               penable,
   input  logic                               pwrite,
   input  logic [ncpu_msr_pkg::MSR_AW-1:0]    paddr,
   input  logic [ncpu_cfg_pkg::NCPU_DW-1:0]   pwdata,
   output logic [ncpu_cfg_pkg::NCPU_DW-1:0]   prdata,
   output logic                               pready,
   output logic                               pslverr,
   // Interrupts
   input  logic [ncpu_cfg_pkg::NCPU_NIRQ-1:0] irqs,
   output logic                               intr
);
   import ncpu_cfg_pkg::*;

   logic [NCPU_DW-1:0]   wdata;       // Shared write value
   logic                 tsr_we;
   logic                 tcr_we;
   logic                 imr_we;
   logic                 psr_ire;
   logic [NCPU_DW-1:0]   tsr;
   logic [NCPU_DW-1:0]   tcr;
   logic [NCPU_DW-1:0]   imr;
   logic [NCPU_DW-1:0]   irr;
   logic                 tsc_irq;
   logic [NCPU_NIRQ-1:0] irq_lines;   // After the timer merge

   ncpu_msr_apb u_msr_apb (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .tsr     (tsr),
      .tcr     (tcr),
      .imr     (imr),
      .irr     (irr),
      .wdata   (wdata),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .imr_we  (imr_we),
      .psr_ire (psr_ire)
   );

   ncpu_tsc u_tsc (
      .clk     (clk),
      .rst     (rst),
      .wdata   (wdata),
      .tsr_we  (tsr_we),
      .tcr_we  (tcr_we),
      .tsr     (tsr),
      .tcr     (tcr),
      .tsc_irq (tsc_irq)
   );

   // Timer ORed onto its line, the rest pass through
   always_comb begin
      irq_lines = irqs;
      irq_lines[NCPU_IRQ_N_TSC] = irqs[NCPU_IRQ_N_TSC] | tsc_irq;
   end

   ncpu_irqc u_irqc (
      .clk     (clk),
      .rst     (rst),
      .irqs    (irq_lines),
      .psr_ire (psr_ire),
      .wdata   (wdata),
      .imr_we  (imr_we),
      .imr     (imr),
      .irr     (irr),
      .intr    (intr)
   );

endmodule

// ==== verif/ncpu_periph_assert.sv ====
/*
 * Protocol and interrupt checks for the system-register top
 * APB ready and error rules, intr gating by PSR.IRE and the
 * timer pending bit only rising with TCR.I set
 */
module ncpu_periph_assert (
   input logic                             clk,
   input logic                             rst,
   input logic                             psel,
   input logic                             penable,
   input logic                             pready,
   input logic                             pslverr,
   input logic                             intr,
   input logic                             psr_ire,
   input logic                             tsc_irq,
   input logic [ncpu_cfg_pkg::NCPU_DW-1:0] tcr
);
   import ncpu_cfg_pkg::*;
   import ncpu_msr_pkg::*;

   int fails = 0;   // Read by the testbench at the end

   // Zero wait states, ready exactly in the access phase
   a_pready: assert property (@(posedge clk) disable iff (rst)
      pready == (psel && penable))
      else begin
         $error("pready does not follow the APB access phase");
         fails++;
      end

   a_pslverr: assert property (@(posedge clk) disable iff (rst)
      pslverr |-> pready)
      else begin
         $error("pslverr raised outside an access cycle");
         fails++;
      end

   a_intr_gate: assert property (@(posedge clk) disable iff (rst)
      intr |-> psr_ire)   // Global enable gates the request
      else begin
         $error("intr high while interrupts are globally disabled");
         fails++;
      end

   a_tsc_rise: assert property (@(posedge clk) disable iff (rst)
      $rose(tsc_irq) |-> tcr[TCR_I_BIT])
      else begin
         $error("timer interrupt rose with TCR.I clear");
         fails++;
      end

endmodule

bind ncpu_periph ncpu_periph_assert u_periph_assert (
   .clk     (clk),
   .rst     (rst),
   .psel    (psel),
   .penable (penable),
   .pready  (pready),
   .pslverr (pslverr),
   .intr    (intr),
   .psr_ire (psr_ire),
   .tsc_irq (tsc_irq),
   .tcr     (tcr)
);

// ==== verif/tb_ncpu_periph.sv ====
/*
 * Testbench for the system-register top level
 * Replays the pattern file as APB accesses, interrupt line
 * changes, waits and intr checks, and compares each read and
 * each error response with the expected column
 */
module tb_ncpu_periph;
   import ncpu_cfg_pkg::*;
   import ncpu_msr_pkg::*;

   localparam int    CLK_PERIOD      = 8;
   localparam int    DRIVE_DLY       = 1;    // Inputs move just after the edge
   localparam int    RESET_CYCLES    = 3;
   localparam int    CYCLES_PER_LINE = 20;   // Timeout budget per command
   localparam string PATTERN_FILE    = "verif/ncpu_periph_patterns.txt";

   logic                 clk;
   logic                 rst;
   logic                 psel;
   logic                 penable;
   logic                 pwrite;
   logic [MSR_AW-1:0]    paddr;
   logic [NCPU_DW-1:0]   pwdata;
   logic [NCPU_DW-1:0]   prdata;
   logic                 pready;
   logic                 pslverr;
   logic [NCPU_NIRQ-1:0] irqs;
   logic                 intr;

   int value_errors  = 0;   // Wrong values seen
   int other_errors  = 0;   // File and format trouble
   int assert_errors = 0;
   int cycle_limit   = 0;   // Set once the pattern file is sized
   int cycle_count   = 0;

   ncpu_periph u_ncpu_periph (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .irqs    (irqs),
      .intr    (intr)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic check_word(input string name, input logic [NCPU_DW-1:0] expv,
                             input logic [NCPU_DW-1:0] actual);
      if (actual !== expv) begin
         $display("FAILED %0t %s expected %h got %h", $time, name, expv, actual);
         value_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic expv, input logic actual);
      if (actual !== expv) begin
         $display("FAILED %0t %s expected %b got %b", $time, name, expv, actual);
         value_errors++;
      end
   endtask

   // Next command line, comment lines skipped
   task automatic next_command(input int fd, input bit report, output bit found,
                               output logic [7:0] op, output logic [MSR_AW-1:0] addr,
                               output logic [NCPU_DW-1:0] data,
                               output logic [NCPU_DW-1:0] expv);
      int               n;
      logic [8*256-1:0] rest;   // Remainder of a comment
      found = 1'b0;
      op    = "?";
      addr  = '0;
      data  = '0;
      expv  = '0;
      while (!found && !$feof(fd)) begin
         n = $fscanf(fd, " %c", op);
         if (n != 1) begin
            return;   // End of file
         end
         if (op == "#") begin
            n = $fgets(rest, fd);
         end else begin
            n = $fscanf(fd, "%h %h %h", addr, data, expv);
            if (n != 3) begin
               if (report) begin
                  $display("Pattern line for opcode %c has missing fields", op);
                  other_errors++;
               end
               return;
            end
            found = 1'b1;
         end
      end
   endtask

   // First pass sizes the timeout
   task automatic count_patterns(output int lines, output int waits);
      int                 fd;
      bit                 found;
      logic [7:0]         op;
      logic [MSR_AW-1:0]  addr;
      logic [NCPU_DW-1:0] data;
      logic [NCPU_DW-1:0] expv;
      lines = 0;
      waits = 0;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0) begin
         return;
      end
      found = 1'b1;
      while (found) begin
         next_command(fd, 1'b0, found, op, addr, data, expv);
         if (found) begin
            lines++;
            if (op == "D") waits += int'(data);
         end
      end
      $fclose(fd);
   endtask

   // One APB transfer, setup then access, starting just after an edge
   task automatic apb_access(input logic wr, input logic [MSR_AW-1:0] addr,
                             input logic [NCPU_DW-1:0] data,
                             output logic [NCPU_DW-1:0] rdata, output logic err,
                             output logic rdy);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      @(posedge clk);
      #DRIVE_DLY penable = 1'b1;
      @(negedge clk);   // Mid access cycle
      rdata = prdata;
      err   = pslverr;
      rdy   = pready;
      @(posedge clk);   // Write lands here
      #DRIVE_DLY psel = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic run_patterns();
      int                 fd;
      bit                 found;
      logic [7:0]         op;
      logic [MSR_AW-1:0]  addr;
      logic [NCPU_DW-1:0] data;
      logic [NCPU_DW-1:0] expv;
      logic [NCPU_DW-1:0] rdata;
      logic               err;
      logic               rdy;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0) begin
         $display("Could not open the pattern file %s", PATTERN_FILE);
         other_errors++;
         return;
      end
      found = 1'b1;
      while (found) begin
         next_command(fd, 1'b1, found, op, addr, data, expv);
         if (found) begin
            case (op)
               "W": begin
                  apb_access(1'b1, addr, data, rdata, err, rdy);
                  check_bit("pready", 1'b1, rdy);   // Zero wait states
                  check_bit($sformatf("pslverr@%h", addr), expv[0], err);
               end
               "R": begin
                  apb_access(1'b0, addr, '0, rdata, err, rdy);
                  check_bit("pready", 1'b1, rdy);
                  check_word($sformatf("prdata@%h", addr), expv, rdata);
               end
               "Q": irqs = data[NCPU_NIRQ-1:0];   // Level lines, no clock needed
               "D": wait_cycles(int'(data));
               "E": check_bit("intr", expv[0], intr);   // Registered, settled by now
               default: begin
                  $display("Unknown opcode %c in the pattern file", op);
                  other_errors++;
               end
            endcase
         end
      end
      $fclose(fd);
   endtask

   initial begin : watchdog
      wait (cycle_limit > 0);
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout after %0d cycles, the run did not finish", cycle_count);
      $display("Testbench failed");
      $finish;
   end

   initial begin : main
      int lines;
      int waits;
      rst     = 1'b1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      irqs    = '0;
      count_patterns(lines, waits);
      cycle_limit = CYCLES_PER_LINE * (lines + 1) + waits + RESET_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY rst = 1'b0;
      run_patterns();
      assert_errors = u_ncpu_periph.u_periph_assert.fails;
      $display("Errors: %0d value, %0d other, %0d assertion",
               value_errors, other_errors, assert_errors);
      if (value_errors == 0 && other_errors == 0 && assert_errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
logic/ncpu_cfg_pkg.sv
logic/ncpu_msr_pkg.sv
logic/ncpu_msr_apb.sv
logic/ncpu_tsc.sv
logic/ncpu_irqc.sv
logic/ncpu_periph.sv
verif/ncpu_periph_assert.sv
verif/tb_ncpu_periph.sv

// ==== verif/ncpu_periph_patterns.txt ====
# op addr data expect, all hex
# W write (expect pslverr), R read (expect prdata), Q irqs=data, D wait data cycles, E expect intr
# Reset values
R 00 00000000 00000000
R 04 00000000 ffffffff
R 08 00000000 00000000
R 0c 00000000 00000000
R 10 00000000 00000000
E 00 00000000 00000000
# Register access, counter stopped
W 00 00000001 00000000
R 00 00000000 00000001
W 04 5a5a00ff 00000000
R 04 00000000 5a5a00ff
W 0c 00001000 00000000
R 0c 00000000 00001000
W 08 12345678 00000001
W 14 deadbeef 00000001
R 14 00000000 00000000
R 08 00000000 00000000
R 04 00000000 5a5a00ff
R 0c 00000000 00001000
R 00 00000000 00000001
W 00 00000000 00000000
R 00 00000000 00000000
# Counting, then frozen by clearing EN
W 10 10000000 00000000
R 0c 00000000 00001001
D 00 0000000a 00000000
R 0c 00000000 0000100d
W 10 00000000 00000000
R 0c 00000000 00001010
R 0c 00000000 00001010
# Timer interrupt on line 0
W 0c 00000010 00000000
W 10 30000020 00000000
D 00 00000028 00000000
R 10 00000000 70000020
W 04 fffffffe 00000000
D 00 00000005 00000000
R 08 00000000 00000001
E 00 00000000 00000000
W 00 00000001 00000000
E 00 00000000 00000001
W 10 00000020 00000000
R 10 00000000 00000020
D 00 00000005 00000000
R 08 00000000 00000000
E 00 00000000 00000000
# External lines through the mask
W 04 0000ff0f 00000000
Q 00 0000f0f0 00000000
D 00 00000005 00000000
R 08 00000000 000000f0
E 00 00000000 00000001
W 00 00000000 00000000
E 00 00000000 00000000
W 00 00000001 00000000
E 00 00000000 00000001
W 04 ffffffff 00000000
D 00 00000005 00000000
R 08 00000000 00000000
E 00 00000000 00000000
Q 00 00000000 00000000
